// File: include/zynq_shell_consts.svh
`ifndef ZYNQ_SHELL_CONSTS_SVH
`define ZYNQ_SHELL_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// apb register window, one 32-bit word per offset
`define CSR_ADDR_W 10
`define CSR_DATA_W 32

// dram address channels toward the ps
`define DRAM_ADDR_W 32

//////////////////////////////////////////////////////////////////////
// dram window and profiler
//////////////////////////////////////////////////////////////////////

// where the accelerator believes dram starts
`define BP_DRAM_BASE 32'h8000_0000

// one profiler bit per 8 MB region
`define PROF_REGIONS 128
`define PROF_MSB 29
`define PROF_LSB 23

//////////////////////////////////////////////////////////////////////
// register offsets
//////////////////////////////////////////////////////////////////////

// control words, written by the ps
`define CSR_SYS_RESET 10'h000
`define CSR_BITBANG 10'h004
`define CSR_DRAM_INIT 10'h008
`define CSR_DRAM_BASE 10'h00C

// status words, low word first
`define CSR_REQ_LO 10'h010
`define CSR_REQ_HI 10'h014
`define CSR_PROF_0 10'h018
`define CSR_PROF_1 10'h01C
`define CSR_PROF_2 10'h020
`define CSR_PROF_3 10'h024

`endif

// File: hdl/zynq_shell_pkg.sv
`default_nettype none

`include "zynq_shell_consts.svh"

package zynq_shell_pkg;

   // register bus
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`CSR_DATA_W-1:0] csr_data_t;

   // dram side
   typedef logic [`DRAM_ADDR_W-1:0] dram_addr_t;

   // request count spans the lo and hi status words
   typedef logic [2*`CSR_DATA_W-1:0] req_count_t;
   typedef logic [`PROF_REGIONS-1:0] profile_t;

   // apb slave, done is the cycle with pready high
   typedef enum logic [1:0] {APB_IDLE, APB_WAIT, APB_DONE} apb_state_e;

   // tag serializer
   typedef enum logic [1:0] {BB_IDLE, BB_DATA, BB_CLK} bb_state_e;

endpackage

`default_nettype wire

// File: hdl/csr_apb_fsm.sv
`default_nettype none

module csr_apb_fsm (
   input  wire                            aclk,
   input  wire                            rst_i,

   // apb requester
   input  wire                            psel_i,
   input  wire                            penable_i,
   input  wire                            pwrite_i,
   input  wire zynq_shell_pkg::csr_addr_t paddr_i,
   input  wire zynq_shell_pkg::csr_data_t pwdata_i,

   // registered answer from the register block
   input  wire zynq_shell_pkg::csr_data_t acc_rdata_i,
   input  wire                            acc_err_i,

   // access strobe toward the register block
   output logic                           acc_v_o,
   output logic                           acc_write_o,
   output zynq_shell_pkg::csr_addr_t      acc_addr_o,
   output zynq_shell_pkg::csr_data_t      acc_wdata_o,

   output zynq_shell_pkg::csr_data_t      prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o
);

   import zynq_shell_pkg::*;

   apb_state_e state_r;
   apb_state_e state_d;

   // setup moves to wait, so wait is the first access cycle
   always_comb begin
      state_d = state_r;
      case (state_r)
         APB_IDLE: begin
            if (psel_i && !penable_i) begin
               state_d = APB_WAIT;
            end
         end
         APB_WAIT: begin
            // requester dropped the transfer
            if (psel_i && penable_i) begin
               state_d = APB_DONE;
            end else begin
               state_d = APB_IDLE;
            end
         end
         APB_DONE: begin
            state_d = APB_IDLE;
         end
         default: begin
            state_d = APB_IDLE;
         end
      endcase
   end

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         state_r <= APB_IDLE;
      end else begin
         state_r <= state_d;
      end
   end

   // one strobe per transfer, only in the first access cycle
   assign acc_v_o     = (state_r == APB_WAIT) && psel_i && penable_i;
   assign acc_write_o = pwrite_i;
   assign acc_addr_o  = paddr_i;
   assign acc_wdata_o = pwdata_i;

   // response lines are quiet outside the done cycle
   assign pready_o  = (state_r == APB_DONE);
   assign prdata_o  = pready_o ? acc_rdata_i : '0;
   assign pslverr_o = pready_o && acc_err_i;

endmodule

`default_nettype wire

// File: hdl/csr_regs.sv
`default_nettype none

`include "zynq_shell_consts.svh"

module csr_regs (
   input  wire                             aclk,
   input  wire                             rst_i,

   // access from the apb slave
   input  wire                             acc_v_i,
   input  wire                             acc_write_i,
   input  wire zynq_shell_pkg::csr_addr_t  acc_addr_i,
   input  wire zynq_shell_pkg::csr_data_t  acc_wdata_i,
   output zynq_shell_pkg::csr_data_t       acc_rdata_o,
   output logic                            acc_err_o,

   // status inputs
   input  wire                             bb_ready_i,
   input  wire zynq_shell_pkg::req_count_t req_count_i,
   input  wire zynq_shell_pkg::profile_t   profile_i,

   // control outputs
   output logic                            sys_reset_n_o,
   output logic                            dram_init_o,
   output zynq_shell_pkg::dram_addr_t      dram_base_o,
   output logic                            bb_v_o,
   output logic                            bb_data_o
);

   import zynq_shell_pkg::*;

   csr_data_t  sys_reset_r;
   csr_data_t  dram_init_r;
   dram_addr_t dram_base_r;

   csr_data_t  acc_rdata_r;
   logic       acc_err_r;

   csr_data_t  rd_word;
   logic       mapped;
   logic       read_only;
   logic       is_bitbang;
   logic       err_d;
   logic       wr_ok;

   //////////////////////////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      rd_word   = '0;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (acc_addr_i)
         `CSR_SYS_RESET: rd_word = sys_reset_r;
         // write-only, reads as zero
         `CSR_BITBANG:   rd_word = '0;
         `CSR_DRAM_INIT: rd_word = dram_init_r;
         `CSR_DRAM_BASE: rd_word = dram_base_r;
         `CSR_REQ_LO: begin
            rd_word   = req_count_i[31:0];
            read_only = 1'b1;
         end
         `CSR_REQ_HI: begin
            rd_word   = req_count_i[63:32];
            read_only = 1'b1;
         end
         `CSR_PROF_0: begin
            rd_word   = profile_i[31:0];
            read_only = 1'b1;
         end
         `CSR_PROF_1: begin
            rd_word   = profile_i[63:32];
            read_only = 1'b1;
         end
         `CSR_PROF_2: begin
            rd_word   = profile_i[95:64];
            read_only = 1'b1;
         end
         `CSR_PROF_3: begin
            rd_word   = profile_i[127:96];
            read_only = 1'b1;
         end
         default: mapped = 1'b0;
      endcase
   end

   // every slverr case is decided here; a busy bit-bang write is dropped
   assign is_bitbang = (acc_addr_i == `CSR_BITBANG);
   assign err_d = !mapped
                  || (acc_write_i && read_only)
                  || (acc_write_i && is_bitbang && !bb_ready_i);
   assign wr_ok = acc_v_i && acc_write_i && !err_d;

   //////////////////////////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         sys_reset_r <= '0;
         dram_init_r <= '0;
         dram_base_r <= '0;
         acc_err_r   <= 1'b0;
      end else begin
         acc_err_r <= acc_v_i && err_d;
         if (wr_ok) begin
            case (acc_addr_i)
               `CSR_SYS_RESET: sys_reset_r <= acc_wdata_i;
               `CSR_DRAM_INIT: dram_init_r <= acc_wdata_i;
               `CSR_DRAM_BASE: dram_base_r <= acc_wdata_i;
               default: ;
            endcase
         end
      end
   end

   // read data lands in the cycle where pready is high
   always_ff @(posedge aclk) begin
      if (acc_v_i) begin
         acc_rdata_r <= acc_write_i ? '0 : rd_word;
      end
   end

   assign acc_rdata_o = acc_rdata_r;
   assign acc_err_o   = acc_err_r;

   // bit 0 of the reset word is the run bit, low holds the core in reset
   assign sys_reset_n_o = sys_reset_r[0];
   assign dram_init_o   = dram_init_r[0];
   assign dram_base_o   = dram_base_r;

   assign bb_v_o    = wr_ok && is_bitbang;
   assign bb_data_o = acc_wdata_i[0];

endmodule

`default_nettype wire

// File: hdl/tag_bitbang.sv
`default_nettype none

module tag_bitbang (
   input  wire  aclk,
   input  wire  rst_i,

   input  wire  bb_v_i,
   input  wire  bb_data_i,
   output logic bb_ready_o,

   // toward the external tag chain
   output logic tag_clk_o,
   output logic tag_data_o
);

   import zynq_shell_pkg::*;

   bb_state_e state_r;
   logic      ready_r;

   // data settles one cycle before the rising tag clock
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         state_r    <= BB_IDLE;
         tag_clk_o  <= 1'b0;
         tag_data_o <= 1'b0;
      end else begin
         case (state_r)
            BB_IDLE: begin
               if (bb_v_i) begin
                  state_r    <= BB_DATA;
                  tag_data_o <= bb_data_i;
               end
            end
            BB_DATA: begin
               state_r   <= BB_CLK;
               tag_clk_o <= 1'b1;
            end
            BB_CLK: begin
               state_r   <= BB_IDLE;
               tag_clk_o <= 1'b0;
            end
            default: begin
               state_r <= BB_IDLE;
            end
         endcase
      end
   end

   // ready comes back a cycle after idle is reached, so the tag clock
   // stays low at least one full cycle before data may change again
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         ready_r <= 1'b0;
      end else begin
         ready_r <= (state_r == BB_IDLE) && !bb_v_i;
      end
   end

   assign bb_ready_o = ready_r;

endmodule

`default_nettype wire

// File: hdl/dram_window.sv
`default_nettype none

`include "zynq_shell_consts.svh"

module dram_window (
   input  wire                             aclk,
   input  wire                             rst_i,
   input  wire                             core_run_i,
   input  wire zynq_shell_pkg::dram_addr_t dram_base_i,

   // accelerator side
   input  wire zynq_shell_pkg::dram_addr_t core_awaddr_i,
   input  wire                             core_awvalid_i,
   output logic                            core_awready_o,
   input  wire zynq_shell_pkg::dram_addr_t core_araddr_i,
   input  wire                             core_arvalid_i,
   output logic                            core_arready_o,

   // ps dram side
   output zynq_shell_pkg::dram_addr_t      dram_awaddr_o,
   output logic                            dram_awvalid_o,
   input  wire                             dram_awready_i,
   output zynq_shell_pkg::dram_addr_t      dram_araddr_o,
   output logic                            dram_arvalid_o,
   input  wire                             dram_arready_i,

   output zynq_shell_pkg::profile_t        profile_o
);

   import zynq_shell_pkg::*;

   profile_t profile_r;

   // strip the accelerator base and move onto the block the ps allocated
   function automatic dram_addr_t window(input dram_addr_t core_addr,
                                         input dram_addr_t base);
      return (core_addr ^ `BP_DRAM_BASE) + base;
   endfunction

   // one-hot region of a request, empty when not valid
   function automatic profile_t region_mark(input logic valid, input dram_addr_t addr);
      profile_t mark;
      mark = '0;
      mark[addr[`PROF_MSB:`PROF_LSB]] = valid;
      return mark;
   endfunction

   assign dram_awaddr_o  = window(core_awaddr_i, dram_base_i);
   assign dram_araddr_o  = window(core_araddr_i, dram_base_i);
   assign dram_awvalid_o = core_awvalid_i;
   assign dram_arvalid_o = core_arvalid_i;
   assign core_awready_o = dram_awready_i;
   assign core_arready_o = dram_arready_i;

   // marks on valid alone, a stalled request still counts as touched
   always_ff @(posedge aclk) begin
      if (rst_i || !core_run_i) begin
         profile_r <= '0;
      end else begin
         profile_r <= profile_r
                      | region_mark(core_awvalid_i, core_awaddr_i)
                      | region_mark(core_arvalid_i, core_araddr_i);
      end
   end

   assign profile_o = profile_r;

endmodule

`default_nettype wire

// File: hdl/dram_req_counter.sv
`default_nettype none

module dram_req_counter (
   input  wire                        aclk,
   input  wire                        rst_i,
   input  wire                        core_run_i,
   input  wire                        aw_fire_i,
   input  wire                        ar_fire_i,
   output zynq_shell_pkg::req_count_t count_o
);

   import zynq_shell_pkg::*;

   req_count_t count_r;
   logic [1:0] step;

   // both channels may fire in the same cycle
   assign step = {1'b0, aw_fire_i} + {1'b0, ar_fire_i};

   always_ff @(posedge aclk) begin
      if (rst_i || !core_run_i) begin
         count_r <= '0;
      end else begin
         count_r <= count_r + req_count_t'(step);
      end
   end

   assign count_o = count_r;

endmodule

`default_nettype wire

// File: hdl/zynq_shell_top.sv
`default_nettype none

module zynq_shell_top (
   input  wire                             aclk,
   input  wire                             rst_i,

   // apb register port from the ps
   input  wire                             psel_i,
   input  wire                             penable_i,
   input  wire                             pwrite_i,
   input  wire zynq_shell_pkg::csr_addr_t  paddr_i,
   input  wire zynq_shell_pkg::csr_data_t  pwdata_i,
   output zynq_shell_pkg::csr_data_t       prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,

   // accelerator control
   output logic                            sys_reset_n_o,
   output logic                            dram_init_o,
   output logic                            tag_clk_o,
   output logic                            tag_data_o,

   // dram address channels, accelerator side
   input  wire zynq_shell_pkg::dram_addr_t core_awaddr_i,
   input  wire                             core_awvalid_i,
   output logic                            core_awready_o,
   input  wire zynq_shell_pkg::dram_addr_t core_araddr_i,
   input  wire                             core_arvalid_i,
   output logic                            core_arready_o,

   // dram address channels, ps side
   output zynq_shell_pkg::dram_addr_t      dram_awaddr_o,
   output logic                            dram_awvalid_o,
   input  wire                             dram_awready_i,
   output zynq_shell_pkg::dram_addr_t      dram_araddr_o,
   output logic                            dram_arvalid_o,
   input  wire                             dram_arready_i
);

   import zynq_shell_pkg::*;

   logic       acc_v;
   logic       acc_write;
   csr_addr_t  acc_addr;
   csr_data_t  acc_wdata;
   csr_data_t  acc_rdata;
   logic       acc_err;

   logic       bb_v;
   logic       bb_data;
   logic       bb_ready;

   logic       core_run;
   dram_addr_t dram_base;
   req_count_t req_count;
   profile_t   profile;

   logic       aw_fire;
   logic       ar_fire;

   //////////////////////////////////////////////////////////////////////
   // register path
   //////////////////////////////////////////////////////////////////////

   csr_apb_fsm i_csr_apb_fsm (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .acc_rdata_i (acc_rdata),
      .acc_err_i   (acc_err),
      .acc_v_o     (acc_v),
      .acc_write_o (acc_write),
      .acc_addr_o  (acc_addr),
      .acc_wdata_o (acc_wdata),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o)
   );

   csr_regs i_csr_regs (
      .aclk          (aclk),
      .rst_i         (rst_i),
      .acc_v_i       (acc_v),
      .acc_write_i   (acc_write),
      .acc_addr_i    (acc_addr),
      .acc_wdata_i   (acc_wdata),
      .acc_rdata_o   (acc_rdata),
      .acc_err_o     (acc_err),
      .bb_ready_i    (bb_ready),
      .req_count_i   (req_count),
      .profile_i     (profile),
      .sys_reset_n_o (core_run),
      .dram_init_o   (dram_init_o),
      .dram_base_o   (dram_base),
      .bb_v_o        (bb_v),
      .bb_data_o     (bb_data)
   );

   assign sys_reset_n_o = core_run;

   tag_bitbang i_tag_bitbang (
      .aclk       (aclk),
      .rst_i      (rst_i),
      .bb_v_i     (bb_v),
      .bb_data_i  (bb_data),
      .bb_ready_o (bb_ready),
      .tag_clk_o  (tag_clk_o),
      .tag_data_o (tag_data_o)
   );

   //////////////////////////////////////////////////////////////////////
   // dram path
   //////////////////////////////////////////////////////////////////////

   dram_window i_dram_window (
      .aclk           (aclk),
      .rst_i          (rst_i),
      .core_run_i     (core_run),
      .dram_base_i    (dram_base),
      .core_awaddr_i  (core_awaddr_i),
      .core_awvalid_i (core_awvalid_i),
      .core_awready_o (core_awready_o),
      .core_araddr_i  (core_araddr_i),
      .core_arvalid_i (core_arvalid_i),
      .core_arready_o (core_arready_o),
      .dram_awaddr_o  (dram_awaddr_o),
      .dram_awvalid_o (dram_awvalid_o),
      .dram_awready_i (dram_awready_i),
      .dram_araddr_o  (dram_araddr_o),
      .dram_arvalid_o (dram_arvalid_o),
      .dram_arready_i (dram_arready_i),
      .profile_o      (profile)
   );

   // handshakes as seen on the ps side
   assign aw_fire = dram_awvalid_o && dram_awready_i;
   assign ar_fire = dram_arvalid_o && dram_arready_i;

   dram_req_counter i_dram_req_counter (
      .aclk       (aclk),
      .rst_i      (rst_i),
      .core_run_i (core_run),
      .aw_fire_i  (aw_fire),
      .ar_fire_i  (ar_fire),
      .count_o    (req_count)
   );

endmodule

`default_nettype wire

// File: verification/zynq_shell_properties.sv
`default_nettype none

module zynq_shell_properties (
   input wire aclk,
   input wire rst_i,
   input wire pready_i,
   input wire pslverr_i,
   input wire tag_clk_i,
   input wire tag_data_i
);

   //////////////////////////////////////////////////////////////////////
   // apb response
   //////////////////////////////////////////////////////////////////////

   // done state never repeats back to back
   pready_single: assert property (@(posedge aclk) disable iff (rst_i)
      pready_i |=> !pready_i)
      else $error("pready stayed high for more than one cycle");

   pslverr_with_pready: assert property (@(posedge aclk) disable iff (rst_i)
      pslverr_i |-> pready_i)
      else $error("pslverr high without pready");

   //////////////////////////////////////////////////////////////////////
   // tag chain
   //////////////////////////////////////////////////////////////////////

   tag_clk_single: assert property (@(posedge aclk) disable iff (rst_i)
      tag_clk_i |=> !tag_clk_i)
      else $error("tag_clk high for more than one cycle");

   // data holds across both edges of the tag clock
   tag_data_hold: assert property (@(posedge aclk) disable iff (rst_i)
      tag_clk_i |-> $stable(tag_data_i) ##1 $stable(tag_data_i))
      else $error("tag_data changed around a tag_clk pulse");

endmodule

bind csr_apb_fsm zynq_shell_properties i_apb_rules (
   .aclk       (aclk),
   .rst_i      (rst_i),
   .pready_i   (pready_o),
   .pslverr_i  (pslverr_o),
   .tag_clk_i  (1'b0),
   .tag_data_i (1'b0)
);

bind tag_bitbang zynq_shell_properties i_tag_rules (
   .aclk       (aclk),
   .rst_i      (rst_i),
   .pready_i   (1'b0),
   .pslverr_i  (1'b0),
   .tag_clk_i  (tag_clk_o),
   .tag_data_i (tag_data_o)
);

`default_nettype wire

// File: verification/zynq_shell_tb.sv
`default_nettype none

`include "zynq_shell_consts.svh"

module zynq_shell_tb;

   import zynq_shell_pkg::*;

   // the directed tests take about 220 cycles, limit with margin
   localparam int TEST_CYCLES = 220;
   localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

   logic       aclk;
   logic       rst_i;
   logic       psel_i;
   logic       penable_i;
   logic       pwrite_i;
   csr_addr_t  paddr_i;
   csr_data_t  pwdata_i;
   csr_data_t  prdata_o;
   logic       pready_o;
   logic       pslverr_o;
   logic       sys_reset_n_o;
   logic       dram_init_o;
   logic       tag_clk_o;
   logic       tag_data_o;
   dram_addr_t core_awaddr_i;
   logic       core_awvalid_i;
   logic       core_awready_o;
   dram_addr_t core_araddr_i;
   logic       core_arvalid_i;
   logic       core_arready_o;
   dram_addr_t dram_awaddr_o;
   logic       dram_awvalid_o;
   logic       dram_awready_i;
   dram_addr_t dram_araddr_o;
   logic       dram_arvalid_o;
   logic       dram_arready_i;

   int         check_errs = 0;
   int         other_errs = 0;
   int         cycles;
   int         pulses = 0;
   logic       tag_clk_seen = 1'b0;
   integer     seed;
   dram_addr_t cur_base;

   zynq_shell_top i_zynq_shell_top (.*);

   initial begin
      aclk = 1'b0;
      forever #20 aclk = ~aclk;
   end

   // rising edges of the tag clock
   always @(negedge aclk) begin
      tag_clk_seen <= tag_clk_o;
      if (tag_clk_o && !tag_clk_seen) begin
         pulses <= pulses + 1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input csr_data_t got, input csr_data_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         check_errs++;
      end
   endtask

   task automatic check_addr(input dram_addr_t got, input dram_addr_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         check_errs++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         check_errs++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // bus tasks
   //////////////////////////////////////////////////////////////////////

   // returns on the falling edge of the cycle with pready high
   task automatic apb_transfer(input logic write, input csr_addr_t addr,
                               input csr_data_t wdata, output csr_data_t rdata,
                               output logic err);
      int access;
      @(negedge aclk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(negedge aclk);
      penable_i = 1'b1;
      access    = 1;
      while (!pready_o && access < 8) begin
         @(negedge aclk);
         access++;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      if (!pready_o) begin
         $display("pready never came for the transfer to offset %h", addr);
         other_errs++;
      end else begin
         check_word(csr_data_t'(access), 32'd2, "access cycles up to pready");
      end
   endtask

   task automatic apb_write(input csr_addr_t addr, input csr_data_t wdata,
                            input logic exp_err);
      csr_data_t rdata;
      logic      err;
      apb_transfer(1'b1, addr, wdata, rdata, err);
      check_bit(err, exp_err, $sformatf("pslverr on write to %h", addr));
   endtask

   task automatic apb_read(input csr_addr_t addr, input csr_data_t exp_data,
                           input logic exp_err);
      csr_data_t rdata;
      logic      err;
      apb_transfer(1'b0, addr, '0, rdata, err);
      check_bit(err, exp_err, $sformatf("pslverr on read of %h", addr));
      if (!exp_err) begin
         check_word(rdata, exp_data, $sformatf("read of %h", addr));
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge aclk);
         psel_i    = 1'b0;
         penable_i = 1'b0;
      end
   endtask

   // one request on one channel, valid for a single cycle
   task automatic dram_request(input logic is_write, input dram_addr_t addr,
                               input logic ready);
      dram_addr_t exp;
      // offset inside the accelerator window, moved onto the allocated base
      exp = addr - `BP_DRAM_BASE + cur_base;
      @(negedge aclk);
      psel_i         = 1'b0;
      penable_i      = 1'b0;
      core_awvalid_i = is_write;
      core_arvalid_i = !is_write;
      core_awaddr_i  = addr;
      core_araddr_i  = addr;
      dram_awready_i = is_write ? ready : 1'b1;
      dram_arready_i = is_write ? 1'b1 : ready;
      #10;
      if (is_write) begin
         check_addr(dram_awaddr_o, exp, "dram aw address");
         check_bit(dram_awvalid_o, 1'b1, "dram aw valid");
         check_bit(core_awready_o, ready, "core aw ready");
      end else begin
         check_addr(dram_araddr_o, exp, "dram ar address");
         check_bit(dram_arvalid_o, 1'b1, "dram ar valid");
         check_bit(core_arready_o, ready, "core ar ready");
      end
      @(negedge aclk);
      core_awvalid_i = 1'b0;
      core_arvalid_i = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_and_access();
      csr_data_t w;
      int        a;
      check_bit(sys_reset_n_o, 1'b0, "sys_reset_n after reset");
      check_bit(dram_init_o, 1'b0, "dram_init after reset");
      check_bit(pready_o, 1'b0, "pready after reset");
      check_bit(pslverr_o, 1'b0, "pslverr after reset");
      check_bit(tag_clk_o, 1'b0, "tag_clk after reset");
      check_bit(tag_data_o, 1'b0, "tag_data after reset");
      for (a = 0; a <= 'h24; a += 4) begin
         apb_read(csr_addr_t'(a), '0, 1'b0);
      end
      w = $random(seed);
      apb_write(`CSR_DRAM_INIT, w, 1'b0);
      apb_read(`CSR_DRAM_INIT, w, 1'b0);
      check_bit(dram_init_o, w[0], "dram_init follows bit 0");
      w = $random(seed);
      apb_write(`CSR_DRAM_BASE, w, 1'b0);
      apb_read(`CSR_DRAM_BASE, w, 1'b0);
      cur_base = w;
      // run bit forced on
      w = $random(seed) | 32'h1;
      apb_write(`CSR_SYS_RESET, w, 1'b0);
      apb_read(`CSR_SYS_RESET, w, 1'b0);
      check_bit(sys_reset_n_o, 1'b1, "sys_reset_n with run bit set");
      apb_write(`CSR_SYS_RESET, '0, 1'b0);
      apb_read(`CSR_SYS_RESET, '0, 1'b0);
      check_bit(sys_reset_n_o, 1'b0, "sys_reset_n with run bit clear");
      apb_write(`CSR_BITBANG, 32'h1, 1'b0);
      apb_read(`CSR_BITBANG, '0, 1'b0);
      idle_cycles(4);
   endtask

   task automatic error_responses();
      apb_write(`CSR_REQ_LO, 32'hdead_beef, 1'b1);
      apb_read(`CSR_REQ_LO, '0, 1'b0);
      apb_write(`CSR_PROF_2, 32'hffff_ffff, 1'b1);
      apb_read(`CSR_PROF_2, '0, 1'b0);
      apb_read(10'h028, '0, 1'b1);
      apb_write(10'h3FC, 32'h1234_5678, 1'b1);
      apb_read(10'h3FC, '0, 1'b1);
      // rejected writes leave the control words alone
      apb_read(`CSR_DRAM_BASE, cur_base, 1'b0);
      apb_read(`CSR_SYS_RESET, '0, 1'b0);
   endtask

   task automatic address_window();
      dram_addr_t a;
      int         i;
      cur_base = $random(seed);
      apb_write(`CSR_DRAM_BASE, cur_base, 1'b0);
      for (i = 0; i < 6; i++) begin
         a = $random(seed);
         dram_request(1'b1, a, 1'b1);
         dram_request(1'b0, ~a, 1'b1);
      end
      // ps side stalls
      a = $random(seed);
      dram_request(1'b1, a, 1'b0);
      dram_request(1'b0, a, 1'b0);
   endtask

   task automatic request_counting();
      profile_t   exp_prof;
      req_count_t exp_count;
      dram_addr_t a;
      int         i;
      int         n;
      exp_prof = '0;
      n        = 0;
      apb_write(`CSR_SYS_RESET, 32'h1, 1'b0);
      for (i = 0; i < 10; i++) begin
         a = $random(seed);
         dram_request(i[0], a, 1'b1);
         exp_prof[a[`PROF_MSB:`PROF_LSB]] = 1'b1;
         n++;
      end
      // a stalled request marks its region but is not counted
      a = $random(seed);
      dram_request(1'b1, a, 1'b0);
      exp_prof[a[`PROF_MSB:`PROF_LSB]] = 1'b1;
      exp_count = req_count_t'(n);
      apb_read(`CSR_REQ_LO, exp_count[31:0], 1'b0);
      apb_read(`CSR_REQ_HI, exp_count[63:32], 1'b0);
      for (i = 0; i < 4; i++) begin
         apb_read(csr_addr_t'(`CSR_PROF_0 + 4 * i), exp_prof[32*i +: 32], 1'b0);
      end
      apb_write(`CSR_SYS_RESET, '0, 1'b0);
      apb_read(`CSR_REQ_LO, '0, 1'b0);
      apb_read(`CSR_REQ_HI, '0, 1'b0);
      for (i = 0; i < 4; i++) begin
         apb_read(csr_addr_t'(`CSR_PROF_0 + 4 * i), '0, 1'b0);
      end
   endtask

   task automatic bitbang_timing();
      int start_pulses;
      idle_cycles(4);
      start_pulses = pulses;
      // tag_data is still high from the earlier write, so a zero shows the update
      apb_write(`CSR_BITBANG, 32'h0, 1'b0);
      // first cycle after the strobe, data out and clock low
      check_bit(tag_data_o, 1'b0, "tag_data in cycle 1");
      check_bit(tag_clk_o, 1'b0, "tag_clk in cycle 1");
      @(negedge aclk);
      check_bit(tag_clk_o, 1'b1, "tag_clk in cycle 2");
      check_bit(tag_data_o, 1'b0, "tag_data in cycle 2");
      @(negedge aclk);
      check_bit(tag_clk_o, 1'b0, "tag_clk in cycle 3");
      idle_cycles(2);
      // second write arrives while the first bit is still going out
      apb_write(`CSR_BITBANG, 32'h1, 1'b0);
      apb_write(`CSR_BITBANG, 32'h0, 1'b1);
      idle_cycles(6);
      check_bit(tag_data_o, 1'b1, "tag_data after the dropped bit");
      check_word(csr_data_t'(pulses - start_pulses), 32'd2, "tag_clk pulse count");
   endtask

   //////////////////////////////////////////////////////////////////////
   // run control
   //////////////////////////////////////////////////////////////////////

   initial begin
      rst_i          = 1'b1;
      psel_i         = 1'b0;
      penable_i      = 1'b0;
      pwrite_i       = 1'b0;
      paddr_i        = '0;
      pwdata_i       = '0;
      core_awaddr_i  = '0;
      core_awvalid_i = 1'b0;
      core_araddr_i  = '0;
      core_arvalid_i = 1'b0;
      dram_awready_i = 1'b0;
      dram_arready_i = 1'b0;
      cur_base       = '0;
      seed           = 32'he78d_b91e;
      repeat (2) @(posedge aclk);
      @(negedge aclk);
      rst_i = 1'b0;
      reset_and_access();
      error_responses();
      address_window();
      request_counting();
      bitbang_timing();
      $display("closing: %0d check errors, %0d other errors", check_errs, other_errs);
      if (check_errs == 0 && other_errs == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge aclk);
         cycles++;
      end
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: zynq_shell_top.f
+incdir+include
hdl/zynq_shell_pkg.sv
hdl/csr_apb_fsm.sv
hdl/csr_regs.sv
hdl/tag_bitbang.sv
hdl/dram_window.sv
hdl/dram_req_counter.sv
hdl/zynq_shell_top.sv
verification/zynq_shell_properties.sv
verification/zynq_shell_tb.sv

// File: Makefile
TOP := zynq_shell_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f zynq_shell_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
